/* hw/pe_pkg.sv */
package pe_pkg;

    // array sizes
    localparam int LANES        = 4;
    localparam int PIX_W        = 8;
    localparam int WT_W         = 16;
    localparam int PSUM_W       = 32;
    localparam int PIX_PER_WORD = 4;
    localparam int WIN_DEPTH    = 12;
    localparam int MAX_S        = 12;
    localparam int SPAD_DEPTH   = LANES * MAX_S;

    // signed saturation limits for partial sums
    localparam logic signed [PSUM_W-1:0] PSUM_MAX = {1'b0, {(PSUM_W-1){1'b1}}};
    localparam logic signed [PSUM_W-1:0] PSUM_MIN = {1'b1, {(PSUM_W-1){1'b0}}};

    // element types are named so that a lane select stays signed
    typedef logic signed [PIX_W-1:0]  pixel_t;
    typedef logic signed [WT_W-1:0]   weight_t;
    typedef logic signed [PSUM_W-1:0] psum_t;

    // pixel 0 sits in the low byte
    typedef pixel_t  [PIX_PER_WORD-1:0] pixel_word_t;
    typedef weight_t [LANES-1:0]        weight_vec_t;
    typedef psum_t   [LANES-1:0]        psum_vec_t;

    typedef struct packed {
        logic [2:0] kernels;
        logic [3:0] filter_width;
        logic [3:0] stride;
        logic [7:0] ofmap_width;
    } pe_config_t;

    typedef enum logic [2:0] {
        IDLE,
        SET,
        LOAD_FILTER,
        COMPUTE,
        IPSUM,
        OUTPUT,
        SHIFT,
        DONE
    } pe_state_t;

endpackage

/* hw/pe_filter_spad.sv */
`timescale 1ns/10ps

module pe_filter_spad import pe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        wr_en,
    input  weight_t     wr_data,
    input  pe_config_t  cfg,
    input  logic [3:0]  tap,
    output weight_vec_t weights
);

    weight_t mem [SPAD_DEPTH];
    logic [$clog2(SPAD_DEPTH)-1:0] wr_ptr;

    // kernel-major write order, one weight per transfer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // one weight per kernel for the current tap
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            if (k < cfg.kernels) begin
                weights[k] = mem[6'(k * cfg.filter_width) + 6'(tap)];
            end else begin
                // idle lanes contribute nothing
                weights[k] = '0;
            end
        end
    end

endmodule

/* hw/pe_ifmap_window.sv */
`timescale 1ns/10ps

module pe_ifmap_window import pe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        load_allow,
    input  logic        ifmap_enable,
    input  pixel_word_t ifmap,
    input  logic        shift_en,
    input  pe_config_t  cfg,
    input  logic [3:0]  tap,
    output logic        ifmap_ready,
    output logic [3:0]  fill,
    output pixel_t      pixel
);

    pixel_t     win [WIN_DEPTH];
    logic [3:0] fill_q;
    logic       load;

    // room for a whole word is required
    assign ifmap_ready = load_allow && (fill_q <= 4'(WIN_DEPTH - PIX_PER_WORD));
    assign load        = ifmap_ready && ifmap_enable;
    assign fill        = fill_q;

    // entry 0 holds the oldest pixel
    assign pixel = win[tap];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_q <= '0;
        end else if (clear) begin
            fill_q <= '0;
        end else if (shift_en) begin
            fill_q <= fill_q - cfg.stride;
        end else if (load) begin
            fill_q <= fill_q + 4'(PIX_PER_WORD);
        end
    end

    // slide by the stride, or append a word behind the valid pixels
    always_ff @(posedge clk) begin
        for (int j = 0; j < WIN_DEPTH; j++) begin
            if (shift_en) begin
                if (j + cfg.stride < WIN_DEPTH) begin
                    win[j] <= win[j + cfg.stride];
                end else begin
                    win[j] <= '0;
                end
            end else if (load && (j >= fill_q) && (j < fill_q + PIX_PER_WORD)) begin
                win[j] <= ifmap[2'(j - fill_q)];
            end
        end
    end

    // controller must close the ifmap port during a slide
    a_no_load_on_shift: assert property (
        @(posedge clk) disable iff (rst)
        shift_en |-> !(ifmap_enable && ifmap_ready)
    );

    a_fill_bound: assert property (
        @(posedge clk) disable iff (rst)
        fill_q <= WIN_DEPTH
    );

endmodule

/* hw/pe_mac_array.sv */
`timescale 1ns/10ps

module pe_mac_array import pe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        mac_clear,
    input  logic        mac_en,
    input  pixel_t      pixel,
    input  weight_vec_t weights,
    input  logic        add_en,
    input  psum_vec_t   ipsum,
    input  logic        opsum_enable,
    input  logic        opsum_ready,
    output psum_vec_t   opsum
);

    psum_t                    acc   [LANES];
    logic signed [PSUM_W:0]   sum_w [LANES];
    psum_vec_t                sat;

    // all kernels share the same pixel each tap
    always_ff @(posedge clk) begin
        for (int k = 0; k < LANES; k++) begin
            if (mac_clear) begin
                acc[k] <= '0;
            end else if (mac_en) begin
                acc[k] <= acc[k] + pixel * weights[k];
            end
        end
    end

    // one extra bit catches the overflow of the ipsum add
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            sum_w[k] = acc[k] + ipsum[k];
            if (sum_w[k][PSUM_W] != sum_w[k][PSUM_W-1]) begin
                // clamp toward the sign of the true result
                sat[k] = sum_w[k][PSUM_W] ? PSUM_MIN : PSUM_MAX;
            end else begin
                sat[k] = sum_w[k][PSUM_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (add_en) begin
            opsum <= sat;
        end
    end

    // held output must not move while the consumer stalls
    a_opsum_hold: assert property (
        @(posedge clk) disable iff (rst)
        (opsum_enable && !opsum_ready) |=> $stable(opsum)
    );

endmodule

/* hw/pe_controller.sv */
`timescale 1ns/10ps

module pe_controller import pe_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic       set_info,
    input  pe_config_t cfg_in,
    input  logic       filter_enable,
    input  logic       ipsum_enable,
    input  logic       opsum_ready,
    input  logic [3:0] fill,
    output pe_config_t cfg,
    output logic       filter_ready,
    output logic       ipsum_ready,
    output logic       opsum_enable,
    output logic       done,
    output logic       filter_wr,
    output logic       spad_clear,
    output logic       load_allow,
    output logic       shift_en,
    output logic       mac_clear,
    output logic       mac_en,
    output logic       add_en,
    output logic [3:0] tap
);

    pe_state_t  state;
    pe_state_t  state_nxt;
    pe_config_t cfg_q;
    logic [5:0] filt_cnt;
    logic [3:0] tap_cnt;
    logic [7:0] col_cnt;
    logic [6:0] filt_total;
    logic       last_filter;
    logic       last_tap;

    // P*S weights per run
    assign filt_total  = cfg_q.kernels * cfg_q.filter_width;
    assign last_filter = filter_wr && ({1'b0, filt_cnt} == filt_total - 7'd1);
    assign last_tap    = mac_en && (tap_cnt == cfg_q.filter_width - 4'd1);

    assign filter_ready = (state == LOAD_FILTER);
    assign filter_wr    = filter_ready && filter_enable;
    assign ipsum_ready  = (state == IPSUM);
    assign add_en       = ipsum_ready && ipsum_enable;
    assign opsum_enable = (state == OUTPUT);
    assign done         = (state == DONE);
    assign spad_clear   = (state == SET) && set_info;
    assign load_allow   = state inside {LOAD_FILTER, COMPUTE, IPSUM, OUTPUT};
    assign shift_en     = (state == SHIFT);
    // accumulators start clean for every column
    assign mac_clear    = (state == LOAD_FILTER) || (state == SHIFT);
    // fill only grows in COMPUTE, so once enough pixels are in all S taps run back to back
    assign mac_en       = (state == COMPUTE) && (fill >= cfg_q.filter_width);
    assign tap          = tap_cnt;
    assign cfg          = cfg_q;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:        if (enable) state_nxt = SET;
            SET:         if (set_info) state_nxt = LOAD_FILTER;
            LOAD_FILTER: if (last_filter) state_nxt = COMPUTE;
            COMPUTE:     if (last_tap) state_nxt = IPSUM;
            IPSUM:       if (add_en) state_nxt = OUTPUT;
            OUTPUT:      if (opsum_ready) state_nxt = SHIFT;
            SHIFT:       state_nxt = (col_cnt == cfg_q.ofmap_width) ? DONE : COMPUTE;
            DONE:        state_nxt = IDLE;
            default:     state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            cfg_q    <= '0;
            filt_cnt <= '0;
            tap_cnt  <= '0;
            col_cnt  <= '0;
        end else begin
            state <= state_nxt;
            if (spad_clear) begin
                cfg_q    <= cfg_in;
                filt_cnt <= '0;
                tap_cnt  <= '0;
                col_cnt  <= '0;
            end
            if (filter_wr) begin
                filt_cnt <= filt_cnt + 6'd1;
            end
            if (mac_en) begin
                tap_cnt <= last_tap ? 4'd0 : tap_cnt + 4'd1;
            end
            // count columns as they leave the PE
            if (opsum_enable && opsum_ready) begin
                col_cnt <= col_cnt + 8'd1;
            end
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(state) &&
        state inside {IDLE, SET, LOAD_FILTER, COMPUTE, IPSUM, OUTPUT, SHIFT, DONE}
    );

endmodule

/* hw/pe_top.sv */
`timescale 1ns/10ps

module pe_top import pe_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic        set_info,
    input  pe_config_t  cfg,
    input  weight_t     filter,
    input  logic        filter_enable,
    output logic        filter_ready,
    input  pixel_word_t ifmap,
    input  logic        ifmap_enable,
    output logic        ifmap_ready,
    input  psum_vec_t   ipsum,
    input  logic        ipsum_enable,
    output logic        ipsum_ready,
    output psum_vec_t   opsum,
    output logic        opsum_enable,
    input  logic        opsum_ready,
    output logic        done
);

    pe_config_t  run_cfg;
    logic        filter_wr;
    logic        spad_clear;
    logic        load_allow;
    logic        shift_en;
    logic        mac_clear;
    logic        mac_en;
    logic        add_en;
    logic [3:0]  tap;
    logic [3:0]  fill;
    weight_vec_t weights;
    pixel_t      pixel;

    pe_controller u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .set_info      (set_info),
        .cfg_in        (cfg),
        .filter_enable (filter_enable),
        .ipsum_enable  (ipsum_enable),
        .opsum_ready   (opsum_ready),
        .fill          (fill),
        .cfg           (run_cfg),
        .filter_ready  (filter_ready),
        .ipsum_ready   (ipsum_ready),
        .opsum_enable  (opsum_enable),
        .done          (done),
        .filter_wr     (filter_wr),
        .spad_clear    (spad_clear),
        .load_allow    (load_allow),
        .shift_en      (shift_en),
        .mac_clear     (mac_clear),
        .mac_en        (mac_en),
        .add_en        (add_en),
        .tap           (tap)
    );

    pe_filter_spad u_spad (
        .clk     (clk),
        .rst     (rst),
        .clear   (spad_clear),
        .wr_en   (filter_wr),
        .wr_data (filter),
        .cfg     (run_cfg),
        .tap     (tap),
        .weights (weights)
    );

    // window is flushed together with the spad at configuration
    pe_ifmap_window u_win (
        .clk          (clk),
        .rst          (rst),
        .clear        (spad_clear),
        .load_allow   (load_allow),
        .ifmap_enable (ifmap_enable),
        .ifmap        (ifmap),
        .shift_en     (shift_en),
        .cfg          (run_cfg),
        .tap          (tap),
        .ifmap_ready  (ifmap_ready),
        .fill         (fill),
        .pixel        (pixel)
    );

    pe_mac_array u_mac (
        .clk          (clk),
        .rst          (rst),
        .mac_clear    (mac_clear),
        .mac_en       (mac_en),
        .pixel        (pixel),
        .weights      (weights),
        .add_en       (add_en),
        .ipsum        (ipsum),
        .opsum_enable (opsum_enable),
        .opsum_ready  (opsum_ready),
        .opsum        (opsum)
    );

endmodule

/* test/pe_tb.sv */
`timescale 1ns/10ps

module pe_tb import pe_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        enable;
    logic        set_info;
    pe_config_t  cfg;
    weight_t     filter;
    logic        filter_enable;
    logic        filter_ready;
    pixel_word_t ifmap;
    logic        ifmap_enable;
    logic        ifmap_ready;
    psum_vec_t   ipsum;
    logic        ipsum_enable;
    logic        ipsum_ready;
    psum_vec_t   opsum;
    logic        opsum_enable;
    logic        opsum_ready;
    logic        done;

    integer    seed = 32'h312b_3ac4;
    int        wt [SPAD_DEPTH];
    int        px [64];
    psum_vec_t ip_mem [16];
    int        cur_p;
    int        cur_s;
    int        cur_u;
    int        cur_f;
    int        col_idx;
    int        done_count;
    int        checks;
    int        errors;
    bit        gaps_on;
    bit        sat_check;

    pe_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // configuration, ipsum mode (0 zero, 1 random, 2 saturating) and gaps per test
    function automatic void select_test(input int n, output pe_config_t c, output int mode,
                                        output bit gaps, output string name);
        case (n)
            0: begin
                c = '{3'd4, 4'd3, 4'd1, 8'd6};
                mode = 0;
                gaps = 0;
                name = "basic";
            end
            1: begin
                c = '{3'd2, 4'd5, 4'd2, 8'd5};
                mode = 1;
                gaps = 0;
                name = "strided";
            end
            2: begin
                c = '{3'd4, 4'd4, 4'd4, 8'd4};
                mode = 2;
                gaps = 0;
                name = "saturation";
            end
            3: begin
                c = '{3'd3, 4'd4, 4'd3, 8'd4};
                mode = 1;
                gaps = 1;
                name = "back-pressure";
            end
            default: begin
                c = '{3'd3, 4'd12, 4'd4, 8'd3};
                mode = 1;
                gaps = 0;
                name = "back-to-back";
            end
        endcase
    endfunction

    function automatic int run_cycles(input pe_config_t c);
        int p;
        int s;
        int u;
        int f;
        p = c.kernels;
        s = c.filter_width;
        u = c.stride;
        f = c.ofmap_width;
        return p * s + ((f - 1) * u + s + 3) / 4 + f * (s + 8);
    endfunction

    // expected opsum for column c, lane k
    function automatic psum_t ref_opsum(input int c, input int k);
        longint sum;
        sum = 0;
        if (k < cur_p) begin
            for (int t = 0; t < cur_s; t++) begin
                sum += longint'(wt[k * cur_s + t]) * longint'(px[c * cur_u + t]);
            end
        end
        sum += longint'(ip_mem[c][k]);
        if (sum > longint'(PSUM_MAX)) begin
            return PSUM_MAX;
        end
        if (sum < longint'(PSUM_MIN)) begin
            return PSUM_MIN;
        end
        return psum_t'(sum);
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic bit skip_cycle();
        return gaps_on && (($random(seed) & 3) == 0);
    endfunction

    task automatic make_data(input int mode, input int npix);
        for (int i = 0; i < cur_p * cur_s; i++) begin
            if (mode == 2) begin
                // lanes 0 and 1 push up, lanes 2 and 3 push down
                wt[i] = 100 + ($random(seed) & 1023);
                if (i / cur_s >= 2) begin
                    wt[i] = -wt[i];
                end
            end else begin
                wt[i] = $random(seed) % 32768;
            end
        end
        for (int i = 0; i < npix; i++) begin
            px[i] = (mode == 2) ? 1 + ($random(seed) & 63) : $random(seed) % 128;
        end
        for (int c = 0; c < cur_f; c++) begin
            for (int k = 0; k < LANES; k++) begin
                case (mode)
                    0: ip_mem[c][k] = '0;
                    1: ip_mem[c][k] = $random(seed);
                    default: begin
                        if (k < 2) begin
                            ip_mem[c][k] = PSUM_MAX - psum_t'($random(seed) & 255);
                        end else begin
                            ip_mem[c][k] = PSUM_MIN + psum_t'($random(seed) & 255);
                        end
                    end
                endcase
            end
        end
    endtask

    // ready is registered, so the value at the falling edge holds until the next rise
    task automatic feed_filters(input int count);
        int i;
        i = 0;
        while (i < count) begin
            @(negedge clk);
            if (skip_cycle()) begin
                filter_enable = 1'b0;
            end else begin
                filter_enable = 1'b1;
                filter = weight_t'(wt[i]);
                if (filter_ready) begin
                    i++;
                end
            end
        end
        @(negedge clk);
        filter_enable = 1'b0;
    endtask

    task automatic feed_ifmap(input int words);
        int w;
        w = 0;
        while (w < words) begin
            @(negedge clk);
            if (skip_cycle()) begin
                ifmap_enable = 1'b0;
            end else begin
                ifmap_enable = 1'b1;
                for (int j = 0; j < PIX_PER_WORD; j++) begin
                    ifmap[j] = pixel_t'(px[w * PIX_PER_WORD + j]);
                end
                if (ifmap_ready) begin
                    w++;
                end
            end
        end
        @(negedge clk);
        ifmap_enable = 1'b0;
    endtask

    task automatic feed_ipsum(input int cols);
        int c;
        c = 0;
        while (c < cols) begin
            @(negedge clk);
            if (skip_cycle()) begin
                ipsum_enable = 1'b0;
            end else begin
                ipsum_enable = 1'b1;
                ipsum = ip_mem[c];
                if (ipsum_ready) begin
                    c++;
                end
            end
        end
        @(negedge clk);
        ipsum_enable = 1'b0;
    endtask

    task automatic run_test(input int n);
        pe_config_t c;
        int         mode;
        bit         gaps;
        string      name;
        int         words;
        int         errs_before;
        int         done_before;
        select_test(n, c, mode, gaps, name);
        cur_p = c.kernels;
        cur_s = c.filter_width;
        cur_u = c.stride;
        cur_f = c.ofmap_width;
        words = ((cur_f - 1) * cur_u + cur_s + 3) / 4;
        make_data(mode, words * PIX_PER_WORD);
        col_idx = 0;
        gaps_on = gaps;
        sat_check = (mode == 2);
        errs_before = errors;
        done_before = done_count;
        @(negedge clk);
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        set_info = 1'b1;
        cfg = c;
        @(negedge clk);
        set_info = 1'b0;
        fork
            feed_filters(cur_p * cur_s);
            feed_ifmap(words);
            feed_ipsum(cur_f);
            wait (done_count != done_before);
        join
        // a few more edges to catch a stray done or column
        repeat (3) @(posedge clk);
        check_value(done_count - done_before, 1, "done pulse count");
        check_value(col_idx, cur_f, "output column count");
        $display("test %0d (%s): %0d columns, %0d errors", n + 1, name, col_idx,
                 errors - errs_before);
    endtask

    always @(posedge clk) begin
        if (done) begin
            done_count++;
        end
    end

    always @(posedge clk) begin : compare_opsum
        if (opsum_enable && opsum_ready) begin
            if (col_idx >= cur_f) begin
                errors++;
                $display("an output column appeared after the last one at %0d ns", $time);
            end else begin
                for (int k = 0; k < LANES; k++) begin
                    check_value(opsum[k], ref_opsum(col_idx, k),
                                $sformatf("column %0d lane %0d", col_idx, k));
                    if (sat_check) begin
                        check_value(opsum[k], (k < 2) ? PSUM_MAX : PSUM_MIN,
                                    $sformatf("clamp column %0d lane %0d", col_idx, k));
                    end
                end
            end
            col_idx++;
        end
    end

    // consumer stalls in random stretches when gaps are on
    initial begin : drive_opsum_ready
        int stretch;
        stretch = 0;
        forever begin
            @(negedge clk);
            if (!gaps_on) begin
                opsum_ready = 1'b1;
            end else if (stretch == 0) begin
                opsum_ready = $random(seed) & 1;
                stretch = 1 + ($random(seed) & 7);
            end else begin
                stretch--;
            end
        end
    end

    initial begin : watchdog
        pe_config_t c;
        int         mode;
        bit         gaps;
        string      name;
        int         budget;
        budget = 10;
        for (int n = 0; n < 5; n++) begin
            select_test(n, c, mode, gaps, name);
            budget += 4 * run_cycles(c);
        end
        repeat (budget) @(posedge clk);
        $display("the run timed out after %0d clock cycles without finishing", budget);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        rst = 1'b1;
        enable = 1'b0;
        set_info = 1'b0;
        cfg = '0;
        filter = '0;
        filter_enable = 1'b0;
        ifmap = '0;
        ifmap_enable = 1'b0;
        ipsum = '0;
        ipsum_enable = 1'b0;
        opsum_ready = 1'b0;
        cur_f = 0;
        col_idx = 0;
        done_count = 0;
        checks = 0;
        errors = 0;
        gaps_on = 1'b0;
        sat_check = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < 5; n++) begin
            run_test(n);
        end
        $display("5 tests run, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
hw/pe_pkg.sv
hw/pe_filter_spad.sv
hw/pe_ifmap_window.sv
hw/pe_mac_array.sv
hw/pe_controller.sv
hw/pe_top.sv
test/pe_tb.sv
